//--- files.f
smc_pkg.sv
smc_ahb_slave.sv
smc_cfg_regs.sv
smc_bank_ctrl.sv
smc_emi_combine.sv
smc_veneer.sv
smc_veneer_asserts.sv
tb_smc_veneer.sv

//--- run.sh
#!/bin/sh
# Build and run the SMC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_smc_veneer -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1

//--- smc_ahb_slave.sv
/*
  SMC AHB-lite front end
  Qualifies address phases, range-checks the address, builds byte enables
  and runs the data phase: wait for bank done, or two ERROR cycles
*/
`timescale 1ns/1ps

module smc_ahb_slave (
  input  logic            hclk,
  input  logic            rst_n,
  input  logic            hsel,
  input  smc_pkg::addr_t  haddr,
  input  smc_pkg::trans_t htrans,
  input  logic            hwrite,
  input  smc_pkg::size_t  hsize,
  input  smc_pkg::data_t  hwdata,
  input  logic            hready,      // Muxed bus ready
  input  logic            done,        // Any bank in HOLD
  input  smc_pkg::data_t  rdata,       // Combined bank read data
  output logic            start,       // One cycle, legal transfers only
  output smc_pkg::bank_t  bank_sel,
  output smc_pkg::addr_t  req_addr,
  output logic            req_write,
  output smc_pkg::be_t    req_be,
  output smc_pkg::data_t  req_wdata,
  output logic            smc_valid,
  output logic            smc_hready,
  output smc_pkg::resp_t  smc_hresp,
  output smc_pkg::data_t  smc_hrdata
);

  typedef enum logic [1:0] {
    DP_IDLE,  // No data phase pending
    DP_WAIT,  // Bank access in progress
    DP_ERR1,  // ERROR, hready low
    DP_ERR2   // ERROR, hready high
  } dp_state_e;

  dp_state_e    dp_state;
  logic         trans_ok;
  logic         take;
  logic         legal;
  smc_pkg::be_t be;

  // Address phase qualify --------
  assign trans_ok = (htrans == smc_pkg::TRANS_NONSEQ) || (htrans == smc_pkg::TRANS_SEQ);
  assign take     = hsel && trans_ok && hready && smc_hready;
  assign legal    = (haddr[31:smc_pkg::SPACE_TOP_BIT] == '0);  // Above bank space -> ERROR

  // Lane enables from size and low address bits
  always_comb begin
    case (hsize)
      3'd0:    be = smc_pkg::be_t'(4'b0001 << haddr[1:0]);
      3'd1:    be = haddr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;  // Word
    endcase
  end

  // Data phase FSM --------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      dp_state <= DP_IDLE;
      start    <= 1'b0;
    end else begin
      start <= take && legal;
      if (take) begin
        dp_state <= legal ? DP_WAIT : DP_ERR1;
      end else begin
        case (dp_state)
          DP_WAIT: if (done) dp_state <= DP_IDLE;  // Hold until bank finishes
          DP_ERR1: dp_state <= DP_ERR2;
          default: dp_state <= DP_IDLE;
        endcase
      end
    end
  end

  // Transfer capture, payload only
  always_ff @(posedge hclk) begin
    if (take) begin
      req_addr  <= haddr;
      req_write <= hwrite;
      req_be    <= be;
      bank_sel  <= haddr[smc_pkg::BANK_LSB +: smc_pkg::BANK_W];
    end
  end

  // Bus response --------
  always_comb begin
    case (dp_state)
      DP_WAIT: smc_hready = done;  // High in bank HOLD cycle
      DP_ERR1: smc_hready = 1'b0;
      default: smc_hready = 1'b1;
    endcase
  end

  assign smc_hresp  = (dp_state == DP_ERR1 || dp_state == DP_ERR2) ?
                      smc_pkg::RESP_ERROR : smc_pkg::RESP_OKAY;
  assign smc_valid  = start;   // Acknowledges a legal address
  assign req_wdata  = hwdata;  // Valid in first data cycle, banks latch it
  assign smc_hrdata = rdata;

endmodule

//--- smc_bank_ctrl.sv
/*
  SMC bank controller
  Runs setup, strobe and hold for one chip select, strobe stretched
  by the bank wait register, and captures read data at strobe end
*/
`timescale 1ns/1ps

module smc_bank_ctrl #(
  parameter smc_pkg::bank_t BANK_ID = '0
) (
  input  logic           hclk,
  input  logic           rst_n,
  input  logic           start,
  input  smc_pkg::bank_t bank_sel,
  input  smc_pkg::addr_t req_addr,
  input  logic           req_write,
  input  smc_pkg::be_t   req_be,
  input  smc_pkg::data_t req_wdata,
  input  smc_pkg::wait_t wait_cnt,   // This bank's register
  input  smc_pkg::data_t data_smc,
  output logic           cs_n,
  output logic           rd_n,
  output smc_pkg::be_t   we_n,
  output smc_pkg::be_t   be,         // Held lane enables, zero when idle
  output logic           wr_n,
  output logic           ext_oe_n,
  output smc_pkg::addr_t addr,
  output smc_pkg::data_t wdata,
  output smc_pkg::data_t rdata,
  output logic           done
);

  smc_pkg::bank_state_e state_q;
  smc_pkg::bank_state_e cur_state;
  smc_pkg::wait_t       cnt_q;
  smc_pkg::addr_t       addr_q;
  smc_pkg::be_t         be_q;
  smc_pkg::data_t       wdata_q;
  smc_pkg::data_t       rdata_q;
  logic                 write_q;
  logic                 go;
  logic                 setup;
  logic                 active;
  logic                 strobe;
  logic                 cur_write;
  smc_pkg::addr_t       cur_addr;
  smc_pkg::be_t         cur_be;
  smc_pkg::data_t       cur_wdata;

  assign go = start && (bank_sel == BANK_ID);

  // SETUP is the start cycle itself, so request comes straight from the front end
  assign cur_state = (state_q == smc_pkg::BANK_IDLE && go) ? smc_pkg::BANK_SETUP : state_q;
  assign setup     = (cur_state == smc_pkg::BANK_SETUP);
  assign active    = (cur_state != smc_pkg::BANK_IDLE);
  assign strobe    = (cur_state == smc_pkg::BANK_STROBE);

  assign cur_write = setup ? req_write : write_q;
  assign cur_addr  = setup ? req_addr  : addr_q;
  assign cur_be    = setup ? req_be    : be_q;
  assign cur_wdata = setup ? req_wdata : wdata_q;

  // Access FSM --------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state_q <= smc_pkg::BANK_IDLE;
      cnt_q   <= '0;
    end else begin
      case (cur_state)
        smc_pkg::BANK_SETUP: begin
          state_q <= smc_pkg::BANK_STROBE;
          cnt_q   <= wait_cnt;  // wait+1 strobe cycles
        end
        smc_pkg::BANK_STROBE: begin
          if (cnt_q == '0) state_q <= smc_pkg::BANK_HOLD;
          else cnt_q <= cnt_q - smc_pkg::wait_t'(1);
        end
        default: state_q <= smc_pkg::BANK_IDLE;  // HOLD back to idle
      endcase
    end
  end

  // Request latch and read capture
  always_ff @(posedge hclk) begin
    if (setup) begin
      addr_q  <= req_addr;
      write_q <= req_write;
      be_q    <= req_be;
      wdata_q <= req_wdata;
    end
    if (strobe && cnt_q == '0 && !write_q) begin
      rdata_q <= data_smc;  // Last strobe cycle
    end
  end

  // EMI strobes --------
  assign cs_n     = !active;
  assign wr_n     = !(active && cur_write);   // Whole write access
  assign ext_oe_n = !(active && cur_write);   // Drive data pins on writes
  assign rd_n     = !(strobe && !cur_write);
  assign we_n     = (strobe && cur_write) ? ~cur_be : '1;
  assign be       = active ? cur_be : '0;
  assign addr     = active ? cur_addr : '0;   // Zero so combiner can OR
  assign wdata    = active ? cur_wdata : '0;
  assign rdata    = rdata_q;
  assign done     = (state_q == smc_pkg::BANK_HOLD);

endmodule

//--- smc_cfg_regs.sv
/*
  SMC configuration registers
  One strobe wait-state register per bank, APB write and read-back
*/
`timescale 1ns/1ps

module smc_cfg_regs (
  input  logic                                   hclk,
  input  logic                                   rst_n,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [4:0]                             paddr,
  input  smc_pkg::data_t                         pwdata,
  output smc_pkg::data_t                         prdata,
  output smc_pkg::wait_t [smc_pkg::NUM_BANKS-1:0] wait_cnt  // One field per bank
);

  smc_pkg::bank_t reg_sel;
  logic           wr_en;

  assign reg_sel = paddr[3:2];                  // Word index picks the bank
  assign wr_en   = psel && penable && pwrite;   // APB access phase

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      for (int i = 0; i < smc_pkg::NUM_BANKS; i++) begin
        wait_cnt[i] <= smc_pkg::DEF_WAIT;
      end
    end else if (wr_en) begin
      wait_cnt[reg_sel] <= smc_pkg::wait_t'(pwdata);  // Low bits only
    end
  end

  // Read-back, zero-extended
  assign prdata = smc_pkg::data_t'(wait_cnt[reg_sel]);

endmodule

//--- smc_emi_combine.sv
/*
  SMC EMI combiner
  Merges the per-bank strobes, address and data onto the external pins,
  picks read data of the selected bank
*/
`timescale 1ns/1ps

module smc_emi_combine (
  input  logic [smc_pkg::NUM_BANKS-1:0]           bank_cs_n,
  input  logic [smc_pkg::NUM_BANKS-1:0]           bank_rd_n,
  input  logic [smc_pkg::NUM_BANKS-1:0]           bank_wr_n,
  input  logic [smc_pkg::NUM_BANKS-1:0]           bank_ext_oe_n,
  input  logic [smc_pkg::NUM_BANKS-1:0]           bank_done,
  input  smc_pkg::be_t   [smc_pkg::NUM_BANKS-1:0] bank_we_n,
  input  smc_pkg::be_t   [smc_pkg::NUM_BANKS-1:0] bank_be,
  input  smc_pkg::addr_t [smc_pkg::NUM_BANKS-1:0] bank_addr,
  input  smc_pkg::data_t [smc_pkg::NUM_BANKS-1:0] bank_wdata,
  input  smc_pkg::data_t [smc_pkg::NUM_BANKS-1:0] bank_rdata,
  output logic [smc_pkg::NUM_BANKS-1:0]           smc_n_cs,
  output logic                                    smc_n_rd,
  output smc_pkg::be_t                            smc_n_we,
  output logic                                    smc_n_wr,
  output logic                                    smc_n_ext_oe,
  output smc_pkg::be_t                            smc_n_be,
  output smc_pkg::addr_t                          smc_addr,
  output smc_pkg::data_t                          smc_data,
  output smc_pkg::data_t                          rdata,
  output logic                                    done,
  output logic                                    smc_busy
);

  smc_pkg::be_t be_or;

  // Per-lane merge --------
  always_comb begin
    smc_n_we = '1;
    be_or    = '0;
    smc_addr = '0;
    smc_data = '0;
    rdata    = '0;
    for (int i = 0; i < smc_pkg::NUM_BANKS; i++) begin
      smc_n_we = smc_n_we & bank_we_n[i];  // Active low, AND
      be_or    = be_or | bank_be[i];
      smc_addr = smc_addr | bank_addr[i];  // Idle banks drive zero
      smc_data = smc_data | bank_wdata[i];
      if (!bank_cs_n[i]) rdata = bank_rdata[i];
    end
  end

  assign smc_n_cs     = bank_cs_n;
  assign smc_n_rd     = &bank_rd_n;
  assign smc_n_wr     = &bank_wr_n;
  assign smc_n_ext_oe = &bank_ext_oe_n;
  assign smc_n_be     = !smc_n_wr ? smc_n_we : ~be_or;  // Writes follow strobes
  assign done         = |bank_done;
  assign smc_busy     = ~&bank_cs_n;                     // Any chip select low

endmodule

//--- smc_pkg.sv
/*
  SMC shared definitions
  Bank decode, bus widths, AHB codes and the bank access states
*/
package smc_pkg;

  // Bank decode --------
  localparam int NUM_BANKS     = 4;   // Banks and chip selects
  localparam int BANK_LSB      = 12;  // Lowest haddr bit of bank index
  localparam int BANK_W        = 2;
  localparam int SPACE_TOP_BIT = 14;  // haddr bits from here up must be zero

  // Bus types --------
  typedef logic [31:0]       addr_t;
  typedef logic [31:0]       data_t;
  typedef logic [3:0]        be_t;    // One bit per byte lane
  typedef logic [3:0]        wait_t;  // Strobe wait states
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [2:0]        size_t;
  typedef logic [1:0]        trans_t;
  typedef logic [1:0]        resp_t;

  localparam wait_t DEF_WAIT = 4'd3;

  // AHB transfer types
  localparam trans_t TRANS_IDLE   = 2'b00;
  localparam trans_t TRANS_BUSY   = 2'b01;
  localparam trans_t TRANS_NONSEQ = 2'b10;
  localparam trans_t TRANS_SEQ    = 2'b11;

  // AHB responses, lite subset
  localparam resp_t RESP_OKAY  = 2'b00;
  localparam resp_t RESP_ERROR = 2'b01;

  // Per-bank access phases
  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_SETUP,
    BANK_STROBE,
    BANK_HOLD
  } bank_state_e;

endpackage

//--- smc_veneer.sv
/*
  SMC top level
  AHB-lite slave to four-bank asynchronous SRAM bus, wait states over APB
*/
`timescale 1ns/1ps

module smc_veneer (
  // APB, on hclk
  input  logic                          hclk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [4:0]                    paddr,
  input  smc_pkg::data_t                pwdata,
  // AHB-lite
  input  logic                          hsel,
  input  smc_pkg::addr_t                haddr,
  input  smc_pkg::trans_t               htrans,
  input  logic                          hwrite,
  input  smc_pkg::size_t                hsize,
  input  smc_pkg::data_t                hwdata,
  input  logic                          hready,
  input  smc_pkg::data_t                data_smc,  // EMI read data
  output smc_pkg::data_t                prdata,
  output smc_pkg::data_t                smc_hrdata,
  output logic                          smc_hready,
  output smc_pkg::resp_t                smc_hresp,
  output logic                          smc_valid,
  // EMI, strobes active low
  output smc_pkg::addr_t                smc_addr,
  output smc_pkg::data_t                smc_data,
  output smc_pkg::be_t                  smc_n_be,
  output logic [smc_pkg::NUM_BANKS-1:0] smc_n_cs,
  output smc_pkg::be_t                  smc_n_we,
  output logic                          smc_n_wr,
  output logic                          smc_n_rd,
  output logic                          smc_n_ext_oe,
  output logic                          smc_busy
);

  // Front end to banks --------
  logic           start;
  smc_pkg::bank_t bank_sel;
  smc_pkg::addr_t req_addr;
  logic           req_write;
  smc_pkg::be_t   req_be;
  smc_pkg::data_t req_wdata;
  logic           done;
  smc_pkg::data_t rdata;

  smc_pkg::wait_t [smc_pkg::NUM_BANKS-1:0] wait_cnt;

  // Bank outputs into combiner --------
  logic [smc_pkg::NUM_BANKS-1:0]           bank_cs_n;
  logic [smc_pkg::NUM_BANKS-1:0]           bank_rd_n;
  logic [smc_pkg::NUM_BANKS-1:0]           bank_wr_n;
  logic [smc_pkg::NUM_BANKS-1:0]           bank_ext_oe_n;
  logic [smc_pkg::NUM_BANKS-1:0]           bank_done;
  smc_pkg::be_t   [smc_pkg::NUM_BANKS-1:0] bank_we_n;
  smc_pkg::be_t   [smc_pkg::NUM_BANKS-1:0] bank_be;
  smc_pkg::addr_t [smc_pkg::NUM_BANKS-1:0] bank_addr;
  smc_pkg::data_t [smc_pkg::NUM_BANKS-1:0] bank_wdata;
  smc_pkg::data_t [smc_pkg::NUM_BANKS-1:0] bank_rdata;

  smc_ahb_slave i_ahb_slave (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hwdata     (hwdata),
    .hready     (hready),
    .done       (done),
    .rdata      (rdata),
    .start      (start),
    .bank_sel   (bank_sel),
    .req_addr   (req_addr),
    .req_write  (req_write),
    .req_be     (req_be),
    .req_wdata  (req_wdata),
    .smc_valid  (smc_valid),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .smc_hrdata (smc_hrdata)
  );

  smc_cfg_regs i_cfg_regs (
    .hclk     (hclk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .wait_cnt (wait_cnt)
  );

  // One controller per chip select
  for (genvar i = 0; i < smc_pkg::NUM_BANKS; i++) begin : g_bank
    smc_bank_ctrl #(
      .BANK_ID (smc_pkg::bank_t'(i))
    ) i_bank_ctrl (
      .hclk      (hclk),
      .rst_n     (rst_n),
      .start     (start),
      .bank_sel  (bank_sel),
      .req_addr  (req_addr),
      .req_write (req_write),
      .req_be    (req_be),
      .req_wdata (req_wdata),
      .wait_cnt  (wait_cnt[i]),
      .data_smc  (data_smc),
      .cs_n      (bank_cs_n[i]),
      .rd_n      (bank_rd_n[i]),
      .we_n      (bank_we_n[i]),
      .be        (bank_be[i]),
      .wr_n      (bank_wr_n[i]),
      .ext_oe_n  (bank_ext_oe_n[i]),
      .addr      (bank_addr[i]),
      .wdata     (bank_wdata[i]),
      .rdata     (bank_rdata[i]),
      .done      (bank_done[i])
    );
  end

  smc_emi_combine i_emi_combine (
    .bank_cs_n     (bank_cs_n),
    .bank_rd_n     (bank_rd_n),
    .bank_wr_n     (bank_wr_n),
    .bank_ext_oe_n (bank_ext_oe_n),
    .bank_done     (bank_done),
    .bank_we_n     (bank_we_n),
    .bank_be       (bank_be),
    .bank_addr     (bank_addr),
    .bank_wdata    (bank_wdata),
    .bank_rdata    (bank_rdata),
    .smc_n_cs      (smc_n_cs),
    .smc_n_rd      (smc_n_rd),
    .smc_n_we      (smc_n_we),
    .smc_n_wr      (smc_n_wr),
    .smc_n_ext_oe  (smc_n_ext_oe),
    .smc_n_be      (smc_n_be),
    .smc_addr      (smc_addr),
    .smc_data      (smc_data),
    .rdata         (rdata),
    .done          (done),
    .smc_busy      (smc_busy)
  );

endmodule

//--- smc_veneer_asserts.sv
/*
  SMC protocol assertions
  EMI chip select and strobe exclusivity, two-cycle AHB ERROR response
*/
`timescale 1ns/1ps

module smc_veneer_asserts (
  input logic                          hclk,
  input logic                          rst_n,
  input logic [smc_pkg::NUM_BANKS-1:0] smc_n_cs,
  input logic                          smc_n_rd,
  input smc_pkg::be_t                  smc_n_we,
  input logic                          smc_hready,
  input smc_pkg::resp_t                smc_hresp
);

  // One bank at a time
  a_one_cs : assert property (@(posedge hclk) disable iff (!rst_n)
    $countones(~smc_n_cs) <= 1)
    else $error("more than one chip select low");

  // Read and write strobes are exclusive
  a_rd_we : assert property (@(posedge hclk) disable iff (!rst_n)
    !(!smc_n_rd && (smc_n_we != 4'b1111)))
    else $error("read and write strobes low together");

  // ERROR first cycle -> ERROR with ready
  a_err_two : assert property (@(posedge hclk) disable iff (!rst_n)
    (smc_hresp == smc_pkg::RESP_ERROR && !smc_hready) |=>
    (smc_hresp == smc_pkg::RESP_ERROR && smc_hready))
    else $error("ERROR response not completed in second cycle");

endmodule

bind smc_veneer smc_veneer_asserts i_asserts (
  .hclk       (hclk),
  .rst_n      (rst_n),
  .smc_n_cs   (smc_n_cs),
  .smc_n_rd   (smc_n_rd),
  .smc_n_we   (smc_n_we),
  .smc_hready (smc_hready),
  .smc_hresp  (smc_hresp)
);

//--- tb_smc_veneer.sv
/*
  SMC testbench
  Random AHB reads and writes against an SRAM model and a byte-array
  reference, APB wait-state setup, response timing and EMI checks
*/
`timescale 1ns/1ps

module tb_smc_veneer;

  localparam int NUM_TXN = 200;
  localparam int LIMIT   = NUM_TXN * (15 + 4) + 8 + 48 + 16;  // Transfers, reset, APB

  logic hclk, rst_n, psel, penable, pwrite, hsel, hwrite, hready;
  logic [4:0] paddr;
  smc_pkg::data_t pwdata, hwdata, data_smc, prdata, smc_hrdata, smc_data;
  smc_pkg::addr_t haddr, smc_addr;
  smc_pkg::trans_t htrans;
  smc_pkg::size_t  hsize;
  smc_pkg::resp_t  smc_hresp;
  smc_pkg::be_t    smc_n_be, smc_n_we;
  logic [smc_pkg::NUM_BANKS-1:0] smc_n_cs;
  logic smc_hready, smc_valid, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  integer seed = 85;
  int     cycles = 0;

  logic [31:0]    sram    [0:4095];   // External SRAM, word wide
  logic [7:0]     ref_mem [0:16383];  // Reference, byte wide
  smc_pkg::wait_t wait_model [smc_pkg::NUM_BANKS];

  // Next and active transfer
  smc_pkg::addr_t cur_addr, act_addr;
  smc_pkg::size_t cur_size, act_size;
  smc_pkg::data_t cur_wdata, act_wdata, act_rdata;
  logic           cur_write, act_write, cur_legal, act_legal;
  int             cur_gap;

  smc_veneer i_smc_veneer (.*);

  always #50 hclk = ~hclk;

  // Fill value depends on every address bit
  function automatic logic [7:0] fill_byte(input logic [13:0] a);
    return a[7:0] ^ {a[13:8], a[1:0]};
  endfunction

  // SRAM model --------
  initial begin
    for (int i = 0; i < 4096; i++) begin
      sram[i] = {fill_byte(14'(i * 4 + 3)), fill_byte(14'(i * 4 + 2)),
                 fill_byte(14'(i * 4 + 1)), fill_byte(14'(i * 4))};
    end
  end

  assign data_smc = !smc_n_rd ? sram[smc_addr[13:2]] : '0;

  always @(posedge hclk) begin
    if (!smc_n_wr) begin
      for (int l = 0; l < 4; l++) begin
        if (!smc_n_we[l]) sram[smc_addr[13:2]][8*l +: 8] = smc_data[8*l +: 8];
      end
    end
  end

  // Failure and checks --------
  task automatic report_fail();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge hclk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      report_fail();
    end
  end

  task automatic check_data(input string name, input smc_pkg::data_t exp,
                            input smc_pkg::data_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_resp(input string name, input smc_pkg::resp_t exp,
                            input smc_pkg::resp_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_be(input string name, input smc_pkg::be_t exp, input smc_pkg::be_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_wait(input string name, input smc_pkg::wait_t exp,
                            input smc_pkg::wait_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_cs(input logic [smc_pkg::NUM_BANKS-1:0] exp,
                          input logic [smc_pkg::NUM_BANKS-1:0] act);
    if (act !== exp) begin
      $display("mismatch at %0t: smc_n_cs expected %b got %b", $time, exp, act);
      report_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      report_fail();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      report_fail();
    end
  endtask

  // No bank active, EMI strobes quiet
  task automatic check_idle();
    check_cs(4'b1111, smc_n_cs);
    check_be("smc_n_we", 4'b1111, smc_n_we);
    check_bit("smc_n_rd", 1'b1, smc_n_rd);
    check_bit("smc_n_wr", 1'b1, smc_n_wr);
    check_bit("smc_valid", 1'b0, smc_valid);
    check_bit("smc_busy", 1'b0, smc_busy);
    check_bit("smc_hready", 1'b1, smc_hready);
  endtask

  // Lanes touched by size and low address bits
  function automatic smc_pkg::be_t lane_enables(input smc_pkg::addr_t a, input smc_pkg::size_t s);
    smc_pkg::be_t be;
    for (int l = 0; l < 4; l++) begin
      if (s == 3'd0)      be[l] = (2'(l) == a[1:0]);
      else if (s == 3'd1) be[l] = (l / 2 == int'(a[1]));
      else                be[l] = 1'b1;
    end
    return be;
  endfunction

  // APB --------
  task automatic apb_write(input int idx, input smc_pkg::data_t val);
    @(posedge hclk);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    penable <= 1'b0;
    paddr   <= 5'(idx * 4);
    pwdata  <= val;
    @(posedge hclk);
    penable <= 1'b1;
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input int idx, output smc_pkg::data_t val);
    @(posedge hclk);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    penable <= 1'b0;
    paddr   <= 5'(idx * 4);
    @(posedge hclk);
    penable <= 1'b1;
    @(posedge hclk);
    val = prdata;  // Access phase value
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // AHB stimulus --------
  task automatic gen_txn();
    logic [31:0] r;
    logic [13:0] offs;
    r         = $random(seed);
    cur_legal = (r[2:0] != 3'd0);  // About one in eight out of range
    cur_write = r[3];
    cur_gap   = int'(r[5:4]);
    cur_size  = 3'({$random(seed)} % 3);
    offs      = 14'($random(seed));
    if (cur_size == 3'd1) offs[0] = 1'b0;
    if (cur_size == 3'd2) offs[1:0] = 2'b00;
    cur_addr = {18'b0, offs};
    if (!cur_legal) cur_addr[14 + ({$random(seed)} % 18)] = 1'b1;
    cur_wdata = $random(seed);
  endtask

  task automatic drive_addr();
    hsel   <= 1'b1;
    htrans <= smc_pkg::TRANS_NONSEQ;
    haddr  <= cur_addr;
    hwrite <= cur_write;
    hsize  <= cur_size;
  endtask

  task automatic drive_idle();
    hsel   <= 1'b0;
    htrans <= smc_pkg::TRANS_IDLE;
  endtask

  // Data phase sampled each cycle until ready
  task automatic watch_data_phase();
    int low_cnt;
    int exp_low;
    logic done_seen;
    smc_pkg::be_t be;
    logic [smc_pkg::NUM_BANKS-1:0] exp_cs;
    low_cnt   = 0;
    done_seen = 1'b0;
    be        = lane_enables(act_addr, act_size);
    exp_cs    = act_legal ? ~(4'b0001 << act_addr[13:12]) : 4'b1111;
    exp_low   = act_legal ? int'(wait_model[act_addr[13:12]]) + 2 : 1;
    while (!done_seen) begin
      @(posedge hclk);
      check_resp("smc_hresp", act_legal ? smc_pkg::RESP_OKAY : smc_pkg::RESP_ERROR, smc_hresp);
      check_cs(exp_cs, smc_n_cs);
      check_bit("smc_valid", act_legal && low_cnt == 0, smc_valid);  // First cycle only
      check_bit("smc_busy", act_legal, smc_busy);
      check_bit("smc_n_wr", !(act_legal && act_write), smc_n_wr);
      check_bit("smc_n_ext_oe", !(act_legal && act_write), smc_n_ext_oe);
      if (smc_hready) begin
        check_count("smc_hready low cycles", exp_low, low_cnt);
        if (act_legal && !act_write) check_data("smc_hrdata", act_rdata, smc_hrdata);
        done_seen = 1'b1;
      end else begin
        low_cnt++;
        if (act_legal && low_cnt >= 2) check_be("smc_n_be", ~be, smc_n_be);  // Strobe cycles
        if (!act_legal) check_be("smc_n_we", 4'b1111, smc_n_we);
      end
    end
  endtask

  // Main sequence --------
  initial begin : main
    smc_pkg::data_t rd;
    smc_pkg::be_t   be;
    logic [13:0]    base;
    hclk    = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = smc_pkg::TRANS_IDLE;
    hwrite  = 1'b0;
    hsize   = '0;
    hwdata  = '0;
    hready  = 1'b1;
    for (int i = 0; i < 16384; i++) ref_mem[i] = fill_byte(14'(i));

    repeat (8) @(posedge hclk);
    rst_n <= 1'b1;
    @(posedge hclk);
    check_idle();
    check_resp("smc_hresp", smc_pkg::RESP_OKAY, smc_hresp);
    check_bit("smc_n_ext_oe", 1'b1, smc_n_ext_oe);

    // Default wait registers, then random ones
    for (int b = 0; b < smc_pkg::NUM_BANKS; b++) begin
      apb_read(b, rd);
      check_wait("prdata default", smc_pkg::DEF_WAIT, smc_pkg::wait_t'(rd));
      wait_model[b] = smc_pkg::wait_t'($random(seed));
      apb_write(b, smc_pkg::data_t'(wait_model[b]));
    end
    for (int b = 0; b < smc_pkg::NUM_BANKS; b++) begin
      apb_read(b, rd);
      check_wait("prdata", wait_model[b], smc_pkg::wait_t'(rd));
    end

    gen_txn();
    @(posedge hclk);
    drive_addr();
    @(posedge hclk);  // Taken by idle front end
    for (int n = 0; n < NUM_TXN; n++) begin
      hwdata   <= cur_wdata;
      act_addr  = cur_addr;
      act_size  = cur_size;
      act_write = cur_write;
      act_legal = cur_legal;
      act_wdata = cur_wdata;
      be        = lane_enables(act_addr, act_size);
      base      = {act_addr[13:2], 2'b00};
      act_rdata = {ref_mem[base + 14'd3], ref_mem[base + 14'd2],
                   ref_mem[base + 14'd1], ref_mem[base]};
      if (act_legal && act_write) begin
        for (int l = 0; l < 4; l++) begin
          if (be[l]) ref_mem[{act_addr[13:2], 2'(l)}] = act_wdata[8*l +: 8];
        end
      end
      if (n < NUM_TXN - 1) gen_txn();
      if (n < NUM_TXN - 1 && cur_gap == 0) drive_addr();  // Pipelined behind this one
      else drive_idle();
      watch_data_phase();
      if (n < NUM_TXN - 1 && cur_gap != 0) begin
        repeat (cur_gap) begin
          @(posedge hclk);
          check_idle();
        end
        drive_addr();
        if (cur_gap % 2 == 1) begin
          hready <= 1'b0;  // Bus busy elsewhere, address held
          @(posedge hclk);
          check_idle();
          hready <= 1'b1;
        end
        @(posedge hclk);
        check_idle();
      end
    end

    // Whole memory against reference model
    for (int w = 0; w < 4096; w++) begin
      base = 14'(w * 4);
      check_data("sram word", {ref_mem[base + 14'd3], ref_mem[base + 14'd2],
                               ref_mem[base + 14'd1], ref_mem[base]}, sram[w]);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule
